// ==== verilog.f ====
common/game_pkg.sv
hw/rom_download.sv
main/main_bus.sv
video/vram_bank.sv
video/video_timing.sv
sound/snd_latch.sv
hw/game_top.sv
test/game_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the game glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module game_tb -o game_sim

./obj_dir/game_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== test/game_tb.sv ====
module game_tb;
    import game_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CYCLE_LIMIT = 3 * FRAME_CYCLES + 5000;

    logic        clk;
    logic        reset;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic        header;
    logic        downloading;
    logic [7:0]  post_data;
    logic        decode;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic        cpu_wr;
    logic        cpu_rd;
    logic [7:0]  cpu_din;
    logic [5:0]  joystick1;
    logic [5:0]  joystick2;
    logic [1:0]  coin;
    logic [1:0]  start;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic        snd_ack;
    logic [7:0]  snd_cmd;
    logic        snd_irq;
    logic [3:0]  pal_sel;
    logic        flip;
    logic        obj_frame;
    logic        irq_n;
    logic        HS;
    logic        VS;
    logic        LHBL;
    logic        LVBL;
    logic        V16;

    // Reference state advanced on the rising edge like the DUT
    logic [7:0]  vram_shadow [VRAM_WORDS];
    logic [7:0]  vscr_shadow [VSCR_WORDS];
    logic [7:0]  obj_shadow  [OBJ_WORDS];
    int          model_h;
    int          model_v;
    logic [4:0]  exp_video;
    logic        lvbl_prev;
    logic        exp_irq_n;
    logic        exp_decode;
    logic [5:0]  exp_cfg;
    logic [7:0]  exp_snd_cmd;
    logic        exp_snd_irq;
    logic        checking = 1'b0;

    logic [31:0] rand_state;
    int          cycles = 0;
    int          checks = 0;
    int          mismatches = 0;
    int          watch_checks = 0;
    int          watch_mismatches = 0;
    int          failures = 0;

    game_top u_dut (.*);

    always #50 clk = ~clk;

    function automatic int next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return int'(rand_state[30:16]);
    endfunction

    function automatic logic [7:0] swap_expect(input logic [21:0] addr, input logic [7:0] data);
        if (addr >= SCR_START && addr < PCM_START) begin
            return {data[3:0], data[7:4]};
        end
        return data;
    endfunction

    function automatic bus_region_e region_of(input logic [15:0] addr);
        int a;
        bus_region_e r;
        a = int'(addr);
        r = REG_NONE;
        if (a >= int'(VRAM_BASE) && a < int'(VRAM_BASE) + VRAM_WORDS) begin
            r = REG_VRAM;
        end else if (a >= int'(VSCR_BASE) && a < int'(VSCR_BASE) + VSCR_WORDS) begin
            r = REG_VSCR;
        end else if (a >= int'(OBJ_BASE) && a < int'(OBJ_BASE) + OBJ_WORDS) begin
            r = REG_OBJ;
        end else if (addr == SND_DATA_ADDR) begin
            r = REG_SND_DATA;
        end else if (addr == SND_ON_ADDR) begin
            r = REG_SND_ON;
        end else if (addr == CFG_ADDR) begin
            r = REG_CFG;
        end else if (addr == IRQ_ACK_ADDR) begin
            r = REG_IRQ_ACK;
        end else if (addr == IO0_ADDR) begin
            r = REG_IO0;
        end else if (addr == IO1_ADDR) begin
            r = REG_IO1;
        end else if (addr == DIPA_ADDR) begin
            r = REG_DIPA;
        end else if (addr == DIPB_ADDR) begin
            r = REG_DIPB;
        end
        return r;
    endfunction

    function automatic logic [7:0] read_expect(input logic [15:0] addr);
        case (region_of(addr))
            REG_VRAM: return vram_shadow[addr[VRAM_AW-1:0]];
            REG_VSCR: return vscr_shadow[addr[VSCR_AW-1:0]];
            REG_OBJ:  return obj_shadow[addr[OBJ_AW-1:0]];
            REG_IO0:  return {joystick1, coin[0], start[0]};
            REG_IO1:  return {joystick2, coin[1], start[1]};
            REG_DIPA: return dipsw_a;
            REG_DIPB: return dipsw_b;
            default:  return 8'hFF;
        endcase
    endfunction

    // Packed as {HS, VS, LHBL, LVBL, V16}
    function automatic logic [4:0] video_expect(input int h, input int v);
        logic hs;
        logic vs;
        hs = (h >= HS_START) && (h < HS_START + HS_LEN);
        vs = (v >= VS_START) && (v < VS_START + VS_LEN);
        return {hs, vs, h < H_ACTIVE, v < V_ACTIVE, ((v >> 4) & 1) != 0};
    endfunction

    task automatic check_result(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            mismatches++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic watch_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        watch_checks++;
        assert (actual === expected) else begin
            watch_mismatches++;
            $display("Mismatch %s: expected %0h, actual %0h at cycle %0d",
                     name, expected, actual, cycles);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            checking    <= 1'b0;
            model_h     <= 0;
            model_v     <= 0;
            exp_video   <= 5'b00110;
            lvbl_prev   <= 1'b1;
            exp_irq_n   <= 1'b1;
            exp_decode  <= 1'b0;
            exp_cfg     <= 6'd0;
            exp_snd_cmd <= 8'd0;
            exp_snd_irq <= 1'b0;
        end else begin
            checking  <= 1'b1;
            exp_video <= video_expect(model_h, model_v);
            if (model_h == H_TOTAL - 1) begin
                model_h <= 0;
                model_v <= (model_v == V_TOTAL - 1) ? 0 : model_v + 1;
            end else begin
                model_h <= model_h + 1;
            end
            // Blank edge beats a simultaneous acknowledge
            lvbl_prev <= exp_video[1];
            if (lvbl_prev && !exp_video[1]) begin
                exp_irq_n <= 1'b0;
            end else if (cpu_wr && region_of(cpu_addr) == REG_IRQ_ACK) begin
                exp_irq_n <= 1'b1;
            end
            if (header && prog_we && downloading && prog_addr[1:0] == 2'd0) begin
                exp_decode <= prog_data[0];
            end
            if (cpu_wr && region_of(cpu_addr) == REG_SND_ON) begin
                exp_snd_irq <= 1'b1;
            end else if (snd_ack) begin
                exp_snd_irq <= 1'b0;
            end
            if (cpu_wr) begin
                case (region_of(cpu_addr))
                    REG_VRAM:     vram_shadow[cpu_addr[VRAM_AW-1:0]] <= cpu_dout;
                    REG_VSCR:     vscr_shadow[cpu_addr[VSCR_AW-1:0]] <= cpu_dout;
                    REG_OBJ:      obj_shadow[cpu_addr[OBJ_AW-1:0]] <= cpu_dout;
                    REG_SND_DATA: exp_snd_cmd <= cpu_dout;
                    REG_CFG:      exp_cfg <= cpu_dout[5:0];
                    default:      ;
                endcase
            end
        end
    end

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            watch_value("video", 32'(exp_video), 32'({HS, VS, LHBL, LVBL, V16}));
            watch_value("decode", 32'(exp_decode), 32'(decode));
            watch_value("config", 32'(exp_cfg), 32'({obj_frame, flip, pal_sel}));
            watch_value("snd_cmd", 32'(exp_snd_cmd), 32'(snd_cmd));
            watch_value("snd_irq", 32'(exp_snd_irq), 32'(snd_irq));
            watch_value("irq_n", 32'(exp_irq_n), 32'(irq_n));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_wr = 1'b1;
        @(negedge clk);
        cpu_wr = 1'b0;
    endtask

    // Data shows one cycle after the strobe and holds afterwards
    task automatic bus_read(input logic [15:0] addr, input logic [7:0] expected,
                            input string name);
        cpu_addr = addr;
        cpu_rd = 1'b1;
        @(negedge clk);
        check_result(name, 32'(expected), 32'(cpu_din));
        cpu_rd = 1'b0;
        @(negedge clk);
        check_result({name, " hold"}, 32'(expected), 32'(cpu_din));
    endtask

    task automatic header_write(input logic [21:0] addr, input logic [7:0] data,
                                input logic expected, input string name);
        prog_addr = addr;
        prog_data = data;
        @(negedge clk);
        check_result(name, 32'(expected), 32'(decode));
    endtask

    initial begin
        logic [21:0] paddr;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [15:0] written [$];
        logic [15:0] edge_addrs [4];
        int          sel;
        int          irq_seen;
        logic        lvbl_was;

        rand_state = 32'd47;
        clk = 1'b0;
        reset = 1'b1;
        prog_addr = 22'd0;
        prog_data = 8'd0;
        prog_we = 1'b0;
        header = 1'b0;
        downloading = 1'b0;
        cpu_addr = 16'd0;
        cpu_dout = 8'd0;
        cpu_wr = 1'b0;
        cpu_rd = 1'b0;
        joystick1 = 6'h3F;
        joystick2 = 6'h3F;
        coin = 2'b11;
        start = 2'b11;
        dipsw_a = 8'hFF;
        dipsw_b = 8'hFF;
        snd_ack = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // Download nibble swap around both region bounds
        downloading = 1'b1;
        prog_we = 1'b1;
        for (int i = 0; i < 300; i++) begin
            sel = next_random() % 3;
            if (sel == 0) begin
                paddr = SCR_START + 22'(next_random() % 16) - 22'd8;
            end else if (sel == 1) begin
                paddr = PCM_START + 22'(next_random() % 16) - 22'd8;
            end else begin
                paddr = 22'((next_random() << 8) ^ next_random());
            end
            data = 8'(next_random());
            prog_addr = paddr;
            prog_data = data;
            @(negedge clk);
            check_result("download swap", 32'(swap_expect(paddr, data)), 32'(post_data));
        end
        header = 1'b1;
        header_write(22'h000000, 8'h01, 1'b1, "decode set");
        header_write(22'h000001, 8'h00, 1'b1, "decode odd address");
        header_write(22'h000004, 8'hFE, 1'b0, "decode clear");
        header_write(22'h000006, 8'h01, 1'b0, "decode unaligned");
        header_write(22'h000008, 8'h03, 1'b1, "decode set again");
        // Header bytes outside a download leave the flag alone
        downloading = 1'b0;
        header_write(22'h000010, 8'h00, 1'b1, "decode outside download");
        downloading = 1'b1;
        header_write(22'h00000C, 8'h00, 1'b0, "decode clear again");
        header = 1'b0;
        prog_we = 1'b0;
        downloading = 1'b0;

        // RAM windows
        for (int i = 0; i < 200; i++) begin
            sel = next_random() % 3;
            if (sel == 0) begin
                addr = VRAM_BASE + 16'(next_random() % VRAM_WORDS);
            end else if (sel == 1) begin
                addr = VSCR_BASE + 16'(next_random() % VSCR_WORDS);
            end else begin
                addr = OBJ_BASE + 16'(next_random() % OBJ_WORDS);
            end
            bus_write(addr, 8'(next_random()));
            written.push_back(addr);
        end
        foreach (written[i]) begin
            bus_read(written[i], read_expect(written[i]), "ram readback");
        end
        edge_addrs = '{16'h3420, 16'h3900, 16'h3A04, 16'h3B04};
        foreach (edge_addrs[i]) begin
            bus_read(edge_addrs[i], 8'hFF, "unmapped edge read");
        end
        for (int i = 0; i < 16; i++) begin
            do begin
                addr = 16'(next_random() * 3);
            end while (region_of(addr) != REG_NONE);
            bus_read(addr, 8'hFF, "unmapped read");
        end

        // Configuration latch and cabinet inputs
        for (int i = 0; i < 10; i++) begin
            data = 8'(next_random());
            bus_write(CFG_ADDR, data);
            check_result("cfg pal_sel", 32'(data[3:0]), 32'(pal_sel));
            check_result("cfg flip", 32'(data[4]), 32'(flip));
            check_result("cfg obj_frame", 32'(data[5]), 32'(obj_frame));
        end
        for (int i = 0; i < 8; i++) begin
            joystick1 = 6'(next_random());
            joystick2 = 6'(next_random());
            coin = 2'(next_random());
            start = 2'(next_random());
            dipsw_a = 8'(next_random());
            dipsw_b = 8'(next_random());
            bus_read(IO0_ADDR, {joystick1, coin[0], start[0]}, "io0 read");
            bus_read(IO1_ADDR, {joystick2, coin[1], start[1]}, "io1 read");
            bus_read(DIPA_ADDR, dipsw_a, "dip a read");
            bus_read(DIPB_ADDR, dipsw_b, "dip b read");
        end

        // Sound command and pending flag
        for (int i = 0; i < 4; i++) begin
            data = 8'(next_random());
            bus_write(SND_DATA_ADDR, data);
            check_result("snd_cmd write", 32'(data), 32'(snd_cmd));
        end
        bus_write(SND_ON_ADDR, 8'h00);
        check_result("snd_irq set", 32'd1, 32'(snd_irq));
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        check_result("snd_irq ack", 32'd0, 32'(snd_irq));
        snd_ack = 1'b1;
        bus_write(SND_ON_ADDR, 8'h00);
        snd_ack = 1'b0;
        check_result("snd_irq set with ack", 32'd1, 32'(snd_irq));
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        check_result("snd_irq final ack", 32'd0, 32'(snd_irq));

        // Two frames of video with each blank interrupt acknowledged
        irq_seen = 0;
        lvbl_was = LVBL;
        while (cycles < 2 * FRAME_CYCLES + H_TOTAL) begin
            @(negedge clk);
            if (lvbl_was && !LVBL) begin
                @(negedge clk);
                check_result("irq on blank", 32'd0, 32'(irq_n));
                irq_seen++;
                repeat (8) @(negedge clk);
                bus_write(IRQ_ACK_ADDR, 8'h00);
                check_result("irq release", 32'd1, 32'(irq_n));
            end
            lvbl_was = LVBL;
        end
        if (irq_seen < 2) begin
            failures++;
            $display("Only %0d vertical blank interrupts seen in two frames", irq_seen);
        end

        $display("Checks %0d + %0d, mismatches %0d + %0d, other errors %0d",
                 checks, watch_checks, mismatches, watch_mismatches, failures);
        if (mismatches + watch_mismatches + failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/game_top.sv ====
module game_top (
    input  logic        clk,
    input  logic        reset,
    // ROM download
    input  logic [21:0] prog_addr,
    input  logic [ 7:0] prog_data,
    input  logic        prog_we,
    input  logic        header,
    input  logic        downloading,
    output logic [ 7:0] post_data,
    output logic        decode,
    // Main CPU bus
    input  logic [15:0] cpu_addr,
    input  logic [ 7:0] cpu_dout,
    input  logic        cpu_wr,
    input  logic        cpu_rd,
    output logic [ 7:0] cpu_din,
    // Cabinet
    input  logic [ 5:0] joystick1,
    input  logic [ 5:0] joystick2,
    input  logic [ 1:0] coin,
    input  logic [ 1:0] start,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    // Sound side
    input  logic        snd_ack,
    output logic [ 7:0] snd_cmd,
    output logic        snd_irq,
    // Configuration and interrupt
    output logic [ 3:0] pal_sel,
    output logic        flip,
    output logic        obj_frame,
    output logic        irq_n,
    // Video timing
    output logic        HS,
    output logic        VS,
    output logic        LHBL,
    output logic        LVBL,
    output logic        V16
);
    import game_pkg::*;

    logic       vram_we;
    logic       vscr_we;
    logic       obj_we;
    logic [7:0] vram_dout;
    logic [7:0] vscr_dout;
    logic [7:0] obj_dout;
    logic       snd_data_we;
    logic       snd_on_we;

    // Header flag only counts while a download is running
    rom_download u_download (
        .clk       ( clk                   ),
        .reset     ( reset                 ),
        .prog_addr ( prog_addr             ),
        .prog_data ( prog_data             ),
        .prog_we   ( prog_we & downloading ),
        .header    ( header                ),
        .post_data ( post_data             ),
        .decode    ( decode                )
    );

    main_bus u_main (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cpu_addr    ( cpu_addr    ),
        .cpu_dout    ( cpu_dout    ),
        .cpu_wr      ( cpu_wr      ),
        .cpu_rd      ( cpu_rd      ),
        .cpu_din     ( cpu_din     ),
        .vram_we     ( vram_we     ),
        .vscr_we     ( vscr_we     ),
        .obj_we      ( obj_we      ),
        .vram_dout   ( vram_dout   ),
        .vscr_dout   ( vscr_dout   ),
        .obj_dout    ( obj_dout    ),
        .snd_data_we ( snd_data_we ),
        .snd_on_we   ( snd_on_we   ),
        .joystick1   ( joystick1   ),
        .joystick2   ( joystick2   ),
        .coin        ( coin        ),
        .start       ( start       ),
        .dipsw_a     ( dipsw_a     ),
        .dipsw_b     ( dipsw_b     ),
        .LVBL        ( LVBL        ),
        .pal_sel     ( pal_sel     ),
        .flip        ( flip        ),
        .obj_frame   ( obj_frame   ),
        .irq_n       ( irq_n       )
    );

    vram_bank u_vram (
        .clk       ( clk                   ),
        .ram_addr  ( cpu_addr[VRAM_AW-1:0] ),
        .cpu_dout  ( cpu_dout              ),
        .vram_we   ( vram_we               ),
        .vscr_we   ( vscr_we               ),
        .obj_we    ( obj_we                ),
        .vram_dout ( vram_dout             ),
        .vscr_dout ( vscr_dout             ),
        .obj_dout  ( obj_dout              )
    );

    video_timing u_timing (
        .clk   ( clk   ),
        .reset ( reset ),
        .HS    ( HS    ),
        .VS    ( VS    ),
        .LHBL  ( LHBL  ),
        .LVBL  ( LVBL  ),
        .V16   ( V16   )
    );

    snd_latch u_sound (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cpu_dout    ( cpu_dout    ),
        .snd_data_we ( snd_data_we ),
        .snd_on_we   ( snd_on_we   ),
        .snd_ack     ( snd_ack     ),
        .snd_cmd     ( snd_cmd     ),
        .snd_irq     ( snd_irq     )
    );

endmodule

// ==== sound/snd_latch.sv ====
module snd_latch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] cpu_dout,
    input  logic       snd_data_we,
    input  logic       snd_on_we,
    input  logic       snd_ack,
    output logic [7:0] snd_cmd,
    output logic       snd_irq
);

    // Command byte for the sound CPU
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_cmd <= 8'd0;
        end else if (snd_data_we) begin
            snd_cmd <= cpu_dout;
        end
    end

    // Pending flag, a new request wins over the acknowledge
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_irq <= 1'b0;
        end else if (snd_on_we) begin
            snd_irq <= 1'b1;
        end else if (snd_ack) begin
            snd_irq <= 1'b0;
        end
    end

endmodule

// ==== video/video_timing.sv ====
module video_timing (
    input  logic clk,
    input  logic reset,
    output logic HS,
    output logic VS,
    output logic LHBL,
    output logic LVBL,
    output logic V16
);
    import game_pkg::*;

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       h_wrap;
    logic       v_wrap;

    assign h_wrap = (hcnt == 9'(H_TOTAL - 1));
    assign v_wrap = (vcnt == 9'(V_TOTAL - 1));

    // Pixel and line counters
    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt <= 9'd0;
            vcnt <= 9'd0;
        end else if (h_wrap) begin
            hcnt <= 9'd0;
            vcnt <= v_wrap ? 9'd0 : vcnt + 9'd1;
        end else begin
            hcnt <= hcnt + 9'd1;
        end
    end

    // Outputs trail the counters by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            HS   <= 1'b0;
            VS   <= 1'b0;
            LHBL <= 1'b1;
            LVBL <= 1'b1;
            V16  <= 1'b0;
        end else begin
            HS   <= (hcnt >= 9'(HS_START)) && (hcnt < 9'(HS_START + HS_LEN));
            VS   <= (vcnt >= 9'(VS_START)) && (vcnt < 9'(VS_START + VS_LEN));
            LHBL <= hcnt < 9'(H_ACTIVE);
            LVBL <= vcnt < 9'(V_ACTIVE);
            V16  <= vcnt[4];
        end
    end

endmodule

// ==== video/vram_bank.sv ====
module vram_bank (
    input  logic                         clk,
    input  logic [game_pkg::VRAM_AW-1:0] ram_addr,
    input  logic [7:0]                   cpu_dout,
    input  logic                         vram_we,
    input  logic                         vscr_we,
    input  logic                         obj_we,
    output logic [7:0]                   vram_dout,
    output logic [7:0]                   vscr_dout,
    output logic [7:0]                   obj_dout
);
    import game_pkg::*;

    logic [7:0] vram_mem [VRAM_WORDS];
    logic [7:0] vscr_mem [VSCR_WORDS];
    logic [7:0] obj_mem  [OBJ_WORDS];

    logic [VSCR_AW-1:0] vscr_addr;
    logic [OBJ_AW-1:0]  obj_addr;

    // Smaller RAMs see only the low address bits
    assign vscr_addr = ram_addr[VSCR_AW-1:0];
    assign obj_addr  = ram_addr[OBJ_AW-1:0];

    // Tile map
    always_ff @(posedge clk) begin
        if (vram_we) begin
            vram_mem[ram_addr] <= cpu_dout;
        end
        vram_dout <= vram_mem[ram_addr];
    end

    // Per column scroll values
    always_ff @(posedge clk) begin
        if (vscr_we) begin
            vscr_mem[vscr_addr] <= cpu_dout;
        end
        vscr_dout <= vscr_mem[vscr_addr];
    end

    // Sprite attributes
    always_ff @(posedge clk) begin
        if (obj_we) begin
            obj_mem[obj_addr] <= cpu_dout;
        end
        obj_dout <= obj_mem[obj_addr];
    end

endmodule

// ==== main/main_bus.sv ====
module main_bus (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] cpu_addr,
    input  logic [ 7:0] cpu_dout,
    input  logic        cpu_wr,
    input  logic        cpu_rd,
    output logic [ 7:0] cpu_din,
    output logic        vram_we,
    output logic        vscr_we,
    output logic        obj_we,
    input  logic [ 7:0] vram_dout,
    input  logic [ 7:0] vscr_dout,
    input  logic [ 7:0] obj_dout,
    output logic        snd_data_we,
    output logic        snd_on_we,
    input  logic [ 5:0] joystick1,
    input  logic [ 5:0] joystick2,
    input  logic [ 1:0] coin,
    input  logic [ 1:0] start,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    input  logic        LVBL,
    output logic [ 3:0] pal_sel,
    output logic        flip,
    output logic        obj_frame,
    output logic        irq_n
);
    import game_pkg::*;

    bus_region_e region;
    bus_region_e rd_region;
    logic        rd_pending;
    logic [7:0]  rd_mux;
    logic [7:0]  din_hold;
    logic        lvbl_l;
    logic        vb_edge;
    logic        irq_ack;

    // Address decoder
    always_comb begin
        region = REG_NONE;
        if (cpu_addr >= VRAM_BASE && cpu_addr < VRAM_BASE + 16'(VRAM_WORDS)) begin
            region = REG_VRAM;
        end else if (cpu_addr >= VSCR_BASE && cpu_addr < VSCR_BASE + 16'(VSCR_WORDS)) begin
            region = REG_VSCR;
        end else if (cpu_addr >= OBJ_BASE && cpu_addr < OBJ_BASE + 16'(OBJ_WORDS)) begin
            region = REG_OBJ;
        end else begin
            case (cpu_addr)
                SND_DATA_ADDR: region = REG_SND_DATA;
                SND_ON_ADDR:   region = REG_SND_ON;
                CFG_ADDR:      region = REG_CFG;
                IRQ_ACK_ADDR:  region = REG_IRQ_ACK;
                IO0_ADDR:      region = REG_IO0;
                IO1_ADDR:      region = REG_IO1;
                DIPA_ADDR:     region = REG_DIPA;
                DIPB_ADDR:     region = REG_DIPB;
                default:       region = REG_NONE;
            endcase
        end
    end

    // Write strobes per target
    assign vram_we     = cpu_wr && (region == REG_VRAM);
    assign vscr_we     = cpu_wr && (region == REG_VSCR);
    assign obj_we      = cpu_wr && (region == REG_OBJ);
    assign snd_data_we = cpu_wr && (region == REG_SND_DATA);
    assign snd_on_we   = cpu_wr && (region == REG_SND_ON);
    assign irq_ack     = cpu_wr && (region == REG_IRQ_ACK);

    // Palette bank, screen flip and object frame
    always_ff @(posedge clk) begin
        if (reset) begin
            pal_sel   <= 4'd0;
            flip      <= 1'b0;
            obj_frame <= 1'b0;
        end else if (cpu_wr && region == REG_CFG) begin
            pal_sel   <= cpu_dout[3:0];
            flip      <= cpu_dout[4];
            obj_frame <= cpu_dout[5];
        end
    end

    // Vertical blank interrupt, a new edge beats the acknowledge
    assign vb_edge = lvbl_l && !LVBL;

    always_ff @(posedge clk) begin
        if (reset) begin
            lvbl_l <= 1'b1;
            irq_n  <= 1'b1;
        end else begin
            lvbl_l <= LVBL;
            if (vb_edge) begin
                irq_n <= 1'b0;
            end else if (irq_ack) begin
                irq_n <= 1'b1;
            end
        end
    end

    // RAM data shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
            rd_region  <= REG_NONE;
        end else begin
            rd_pending <= cpu_rd;
            if (cpu_rd) begin
                rd_region <= region;
            end
        end
    end

    always_comb begin
        case (rd_region)
            REG_VRAM: rd_mux = vram_dout;
            REG_VSCR: rd_mux = vscr_dout;
            REG_OBJ:  rd_mux = obj_dout;
            REG_IO0:  rd_mux = {joystick1, coin[0], start[0]};
            REG_IO1:  rd_mux = {joystick2, coin[1], start[1]};
            REG_DIPA: rd_mux = dipsw_a;
            REG_DIPB: rd_mux = dipsw_b;
            default:  rd_mux = 8'hFF;
        endcase
    end

    // Read value stays put until the next read
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            din_hold <= rd_mux;
        end
    end

    assign cpu_din = rd_pending ? rd_mux : din_hold;

endmodule

// ==== hw/rom_download.sv ====
module rom_download (
    input  logic        clk,
    input  logic        reset,
    input  logic [21:0] prog_addr,
    input  logic [ 7:0] prog_data,
    input  logic        prog_we,
    input  logic        header,
    output logic [ 7:0] post_data,
    output logic        decode
);
    import game_pkg::*;

    logic in_scr;
    logic hdr_flag_we;

    // Scroll tiles are stored with swapped nibbles in the ROM set
    assign in_scr = (prog_addr >= SCR_START) && (prog_addr < PCM_START);

    always_comb begin
        post_data = prog_data;
        if (in_scr) begin
            post_data = {prog_data[3:0], prog_data[7:4]};
        end
    end

    // Only the first byte of each header word carries the flag
    assign hdr_flag_we = header && prog_we && (prog_addr[1:0] == 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            decode <= 1'b0;
        end else if (hdr_flag_we) begin
            decode <= prog_data[0];
        end
    end

endmodule

// ==== common/game_pkg.sv ====
package game_pkg;

    // Regions seen by the main CPU decoder
    typedef enum logic [3:0] {
        REG_NONE,
        REG_VRAM,
        REG_VSCR,
        REG_OBJ,
        REG_SND_DATA,
        REG_SND_ON,
        REG_CFG,
        REG_IRQ_ACK,
        REG_IO0,
        REG_IO1,
        REG_DIPA,
        REG_DIPB
    } bus_region_e;

    // Main CPU memory map
    localparam logic [15:0] VRAM_BASE = 16'h3000;
    localparam int VRAM_WORDS = 1024;
    localparam logic [15:0] VSCR_BASE = 16'h3400;
    localparam int VSCR_WORDS = 32;
    localparam logic [15:0] OBJ_BASE = 16'h3800;
    localparam int OBJ_WORDS = 256;

    localparam int VRAM_AW = $clog2(VRAM_WORDS);
    localparam int VSCR_AW = $clog2(VSCR_WORDS);
    localparam int OBJ_AW = $clog2(OBJ_WORDS);

    localparam logic [15:0] SND_DATA_ADDR = 16'h3A00;
    localparam logic [15:0] SND_ON_ADDR = 16'h3A01;
    localparam logic [15:0] CFG_ADDR = 16'h3A02;
    localparam logic [15:0] IRQ_ACK_ADDR = 16'h3A03;

    // Cabinet reads, all bits active low as wired on the cabinet
    // IO0 = {joystick1[5:0], coin[0], start[0]}
    // IO1 = {joystick2[5:0], coin[1], start[1]}
    localparam logic [15:0] IO0_ADDR = 16'h3B00;
    localparam logic [15:0] IO1_ADDR = 16'h3B01;
    localparam logic [15:0] DIPA_ADDR = 16'h3B02;
    localparam logic [15:0] DIPB_ADDR = 16'h3B03;

    // Horizontal timing in pixels
    localparam int H_TOTAL = 384;
    localparam int H_ACTIVE = 256;
    localparam int HS_START = 288;
    localparam int HS_LEN = 32;

    // Vertical timing in lines
    localparam int V_TOTAL = 264;
    localparam int V_ACTIVE = 224;
    localparam int VS_START = 240;
    localparam int VS_LEN = 8;

    // Scroll graphics byte range inside the download stream
    localparam logic [21:0] SCR_START = 22'h04_0000;
    localparam logic [21:0] PCM_START = 22'h0C_0000;

endpackage
